/* hdl/burst_fifo.sv */
`timescale 1ns/100ps

module burst_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = 4
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t pop_data,
   output logic     full,
   output logic     empty
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t         mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;

   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
      if (ptr == ptr_w'(depth - 1)) begin
         return '0;                              // Depth need not be a power of two.
      end
      return ptr + 1'b1;
   endfunction

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop) rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= push_data;
   end

   assign pop_data = mem[rd_ptr];               // Head shown with no read latency.
   assign full     = (count == cnt_w'(depth));
   assign empty    = (count == '0);

   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

/* hdl/burst_master.sv */
`timescale 1ns/100ps

module burst_master #(
   parameter int ret_depth = 4
) (
   input  logic                         clk,
   input  logic                         rst_n,
   // Host side.
   input  logic                         cmd_valid,
   input  burst_pkg::host_cmd_t         cmd,
   output logic                         cmd_ready,
   output logic                         rd_out_valid,
   output burst_pkg::rd_beat_t          rd_out,
   input  logic                         rd_out_ready,
   output logic                         wr_done,
   output logic [burst_pkg::id_w-1:0]   wr_done_id,
   // Write address.
   output logic                         wr_addr_valid,
   output burst_pkg::addr_cmd_t         wr_addr,
   input  logic                         wr_addr_ready,
   // Write data.
   output logic                         wr_data_valid,
   output burst_pkg::wr_beat_t          wr_data,
   input  logic                         wr_data_ready,
   // Read address.
   output logic                         rd_addr_valid,
   output burst_pkg::addr_cmd_t         rd_addr,
   input  logic                         rd_addr_ready,
   // Read data.
   input  logic                         rd_data_valid,
   input  burst_pkg::rd_beat_t          rd_data,
   output logic                         rd_data_ready
);

   import burst_pkg::*;

   typedef enum logic [1:0] {
      S_RESET,
      S_IDLE,
      S_ADDR,
      S_DATA
   } state_t;

   state_t           state;
   host_cmd_t        cmd_q;
   addr_cmd_t        burst_cmd;
   logic [len_w-1:0] beat_cnt;
   logic             beat_last;
   logic             cmd_accept;
   logic             wr_addr_hs;
   logic             rd_addr_hs;
   logic             wr_data_hs;
   logic             ret_push;
   logic             ret_pop;
   logic             ret_full;
   logic             ret_empty;

   assign cmd_ready  = (state == S_IDLE);       // Held low for a cycle after reset.
   assign cmd_accept = cmd_valid && cmd_ready;

   assign burst_cmd = '{addr: cmd_q.addr, len: cmd_q.len, id: cmd_q.id};

   assign wr_addr_valid = (state == S_ADDR) && cmd_q.is_write;
   assign rd_addr_valid = (state == S_ADDR) && !cmd_q.is_write;
   assign wr_addr       = burst_cmd;
   assign rd_addr       = burst_cmd;
   assign wr_addr_hs    = wr_addr_valid && wr_addr_ready;
   assign rd_addr_hs    = rd_addr_valid && rd_addr_ready;

   assign beat_last     = (beat_cnt == cmd_q.len);
   assign wr_data_valid = (state == S_DATA);
   assign wr_data       = '{data: cmd_q.data + data_w'(beat_cnt),
                            strb: cmd_q.strb,
                            id:   cmd_q.id,
                            last: beat_last};
   assign wr_data_hs    = wr_data_valid && wr_data_ready;

   // cmd_q is not reloaded until the cycle after the pulse.
   assign wr_done_id = cmd_q.id;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= S_RESET;
         beat_cnt <= '0;
         wr_done  <= 1'b0;
      end else begin
         wr_done <= wr_data_hs && beat_last;
         case (state)
            S_RESET: state <= S_IDLE;
            S_IDLE: begin
               if (cmd_accept) state <= S_ADDR;
            end
            S_ADDR: begin
               if (wr_addr_hs) begin
                  state    <= S_DATA;
                  beat_cnt <= '0;
               end else if (rd_addr_hs) begin
                  state <= S_IDLE;                // Read runs on without the FSM.
               end
            end
            S_DATA: begin
               if (wr_data_hs) begin
                  if (beat_last) state <= S_IDLE;
                  else beat_cnt <= beat_cnt + 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_accept) cmd_q <= cmd;
   end

   // Read return path with host back-pressure.
   assign rd_data_ready = !ret_full;
   assign ret_push      = rd_data_valid && rd_data_ready;
   assign rd_out_valid  = !ret_empty;
   assign ret_pop       = rd_out_valid && rd_out_ready;

   burst_fifo #(
      .payload_t (rd_beat_t),
      .depth     (ret_depth)
   ) ret_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (ret_push),
      .push_data (rd_data),
      .pop       (ret_pop),
      .pop_data  (rd_out),
      .full      (ret_full),
      .empty     (ret_empty)
   );

   a_wr_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
      wr_data_valid && !wr_data_ready |=> wr_data_valid && $stable(wr_data));

endmodule

/* hdl/burst_mem_slave.sv */
`timescale 1ns/100ps

module burst_mem_slave #(
   parameter int mem_words = 256,
   parameter int cmd_depth = 4
) (
   input  logic                 clk,
   input  logic                 rst_n,
   // Write address.
   input  logic                 wr_addr_valid,
   input  burst_pkg::addr_cmd_t wr_addr,
   output logic                 wr_addr_ready,
   // Write data.
   input  logic                 wr_data_valid,
   input  burst_pkg::wr_beat_t  wr_data,
   output logic                 wr_data_ready,
   // Read address.
   input  logic                 rd_addr_valid,
   input  burst_pkg::addr_cmd_t rd_addr,
   output logic                 rd_addr_ready,
   // Read data.
   output logic                 rd_data_valid,
   output burst_pkg::rd_beat_t  rd_data,
   input  logic                 rd_data_ready
);

   import burst_pkg::*;

   localparam int idx_w = $clog2(mem_words);

   logic [data_w-1:0] mem [mem_words];
   addr_cmd_t         wr_head;
   addr_cmd_t         rd_head;
   logic              wr_full;
   logic              wr_empty;
   logic              rd_full;
   logic              rd_empty;
   logic              wr_push;
   logic              rd_push;
   logic              wr_pop;
   logic              rd_pop;
   logic              wr_hs;
   logic              wr_final;
   logic              rd_hs;
   logic              rd_final;
   logic              rd_active;
   logic [len_w-1:0]  wr_cnt;
   logic [len_w-1:0]  rd_cnt;
   logic [len_w-1:0]  rd_len;
   logic [id_w-1:0]   rd_id;
   logic [idx_w-1:0]  wr_word;
   logic [idx_w-1:0]  rd_start;
   logic [idx_w-1:0]  rd_word;                  // Next word to fetch.
   logic [data_w-1:0] rd_data_q;

   assign wr_addr_ready = !wr_full;
   assign rd_addr_ready = !rd_full;
   assign wr_push       = wr_addr_valid && wr_addr_ready;
   assign rd_push       = rd_addr_valid && rd_addr_ready;

   burst_fifo #(
      .payload_t (addr_cmd_t),
      .depth     (cmd_depth)
   ) wr_cmd_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (wr_push),
      .push_data (wr_addr),
      .pop       (wr_pop),
      .pop_data  (wr_head),
      .full      (wr_full),
      .empty     (wr_empty)
   );

   burst_fifo #(
      .payload_t (addr_cmd_t),
      .depth     (cmd_depth)
   ) rd_cmd_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (rd_push),
      .push_data (rd_addr),
      .pop       (rd_pop),
      .pop_data  (rd_head),
      .full      (rd_full),
      .empty     (rd_empty)
   );

   // Write side: beats only while a command sits at the head.
   assign wr_data_ready = !wr_empty;
   assign wr_hs         = wr_data_valid && wr_data_ready;
   assign wr_final      = (wr_cnt == wr_head.len);
   assign wr_pop        = wr_hs && wr_final;
   assign wr_word       = wr_head.addr[idx_w+1:2] + idx_w'(wr_cnt);   // Wraps at the top.

   always_ff @(posedge clk) begin
      if (wr_hs) begin
         for (int b = 0; b < strb_w; b++) begin
            if (wr_data.strb[b]) mem[wr_word][8*b +: 8] <= wr_data.data[8*b +: 8];
         end
      end
   end

   // Read engine.
   assign rd_start      = rd_head.addr[idx_w+1:2];
   assign rd_pop        = !rd_active && !rd_empty;
   assign rd_data_valid = rd_active;
   assign rd_hs         = rd_data_valid && rd_data_ready;
   assign rd_final      = (rd_cnt == rd_len);
   assign rd_data       = '{data: rd_data_q, id: rd_id, last: rd_final};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_cnt    <= '0;
         rd_cnt    <= '0;
         rd_active <= 1'b0;
      end else begin
         if (wr_hs) wr_cnt <= wr_final ? '0 : wr_cnt + 1'b1;
         if (rd_pop) begin
            rd_active <= 1'b1;
            rd_cnt    <= '0;
         end else if (rd_hs) begin
            if (rd_final) rd_active <= 1'b0;
            else rd_cnt <= rd_cnt + 1'b1;
         end
      end
   end

   // Beat data is registered so it holds while the master stalls.
   always_ff @(posedge clk) begin
      if (rd_pop) begin
         rd_data_q <= mem[rd_start];
         rd_word   <= rd_start + 1'b1;
         rd_len    <= rd_head.len;
         rd_id     <= rd_head.id;
      end else if (rd_hs && !rd_final) begin
         rd_data_q <= mem[rd_word];
         rd_word   <= rd_word + 1'b1;
      end
   end

   a_wr_id_match: assert property (@(posedge clk) disable iff (!rst_n)
      wr_hs |-> wr_data.id == wr_head.id);
   a_wr_last_match: assert property (@(posedge clk) disable iff (!rst_n)
      wr_hs |-> wr_data.last == wr_final);

endmodule

/* hdl/burst_pkg.sv */
package burst_pkg;

   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int len_w  = 8;                    // Beats minus one.
   localparam int id_w   = 4;
   localparam int strb_w = data_w / 8;

   // Shared by the write-address and read-address channels.
   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [len_w-1:0]  len;
      logic [id_w-1:0]   id;
   } addr_cmd_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
      logic [id_w-1:0]   id;
      logic              last;
   } wr_beat_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [id_w-1:0]   id;
      logic              last;
   } rd_beat_t;

   typedef struct packed {
      logic              is_write;
      logic [addr_w-1:0] addr;
      logic [len_w-1:0]  len;
      logic [id_w-1:0]   id;
      logic [data_w-1:0] data;                  // First beat, later beats add the index.
      logic [strb_w-1:0] strb;
   } host_cmd_t;

endpackage

/* hdl/burst_subsystem_top.sv */
`timescale 1ns/100ps

module burst_subsystem_top #(
   parameter int mem_words = 256,
   parameter int cmd_depth = 4,
   parameter int ret_depth = 4
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       cmd_valid,
   input  burst_pkg::host_cmd_t       cmd,
   output logic                       cmd_ready,
   output logic                       rd_out_valid,
   output burst_pkg::rd_beat_t        rd_out,
   input  logic                       rd_out_ready,
   output logic                       wr_done,
   output logic [burst_pkg::id_w-1:0] wr_done_id
);

   import burst_pkg::*;

   logic      wr_addr_valid;
   logic      wr_addr_ready;
   addr_cmd_t wr_addr;
   logic      wr_data_valid;
   logic      wr_data_ready;
   wr_beat_t  wr_data;
   logic      rd_addr_valid;
   logic      rd_addr_ready;
   addr_cmd_t rd_addr;
   logic      rd_data_valid;
   logic      rd_data_ready;
   rd_beat_t  rd_data;

   burst_master #(
      .ret_depth (ret_depth)
   ) master0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .cmd_valid     (cmd_valid),
      .cmd           (cmd),
      .cmd_ready     (cmd_ready),
      .rd_out_valid  (rd_out_valid),
      .rd_out        (rd_out),
      .rd_out_ready  (rd_out_ready),
      .wr_done       (wr_done),
      .wr_done_id    (wr_done_id),
      .wr_addr_valid (wr_addr_valid),
      .wr_addr       (wr_addr),
      .wr_addr_ready (wr_addr_ready),
      .wr_data_valid (wr_data_valid),
      .wr_data       (wr_data),
      .wr_data_ready (wr_data_ready),
      .rd_addr_valid (rd_addr_valid),
      .rd_addr       (rd_addr),
      .rd_addr_ready (rd_addr_ready),
      .rd_data_valid (rd_data_valid),
      .rd_data       (rd_data),
      .rd_data_ready (rd_data_ready)
   );

   burst_mem_slave #(
      .mem_words (mem_words),
      .cmd_depth (cmd_depth)
   ) slave0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .wr_addr_valid (wr_addr_valid),
      .wr_addr       (wr_addr),
      .wr_addr_ready (wr_addr_ready),
      .wr_data_valid (wr_data_valid),
      .wr_data       (wr_data),
      .wr_data_ready (wr_data_ready),
      .rd_addr_valid (rd_addr_valid),
      .rd_addr       (rd_addr),
      .rd_addr_ready (rd_addr_ready),
      .rd_data_valid (rd_data_valid),
      .rd_data       (rd_data),
      .rd_data_ready (rd_data_ready)
   );

endmodule

/* project.f */
+incdir+verification
hdl/burst_pkg.sv
hdl/burst_fifo.sv
hdl/burst_master.sv
hdl/burst_mem_slave.sv
hdl/burst_subsystem_top.sv
verification/burst_subsystem_tb.sv

/* verification/burst_tb_table.svh */
// Columns: is_write, byte address, beats minus one, id, first data word, strobe,
// randomized rd_out_ready, wait for the last read beat, expected first read word.

typedef struct packed {
   logic              is_write;
   logic [addr_w-1:0] addr;
   logic [len_w-1:0]  len;
   logic [id_w-1:0]   id;
   logic [data_w-1:0] data;
   logic [strb_w-1:0] strb;
   logic              rand_ready;
   logic              wait_done;                // Writes always wait for wr_done.
   logic [data_w-1:0] exp_first;                // Zero on write rows.
} table_entry_t;

localparam int n_rows = 11;

localparam table_entry_t table_rows [n_rows] = '{
   // Full write then read back.
   '{1'b1, 32'h0000_0000, 8'd3, 4'd1,  32'h1000_0000, 4'hf, 1'b0, 1'b1, 32'h0000_0000},
   '{1'b0, 32'h0000_0000, 8'd3, 4'd2,  32'h0000_0000, 4'h0, 1'b0, 1'b1, 32'h1000_0000},
   // Bytes 0 and 2 only, over words 2 and 3.
   '{1'b1, 32'h0000_0008, 8'd1, 4'd3,  32'haabb_ccdd, 4'h5, 1'b0, 1'b1, 32'h0000_0000},
   '{1'b0, 32'h0000_0008, 8'd1, 4'd4,  32'h0000_0000, 4'h0, 1'b0, 1'b1, 32'h10bb_00dd},
   // Eight beats, then three reads back to back.
   '{1'b1, 32'h0000_0100, 8'd7, 4'd5,  32'h2000_0000, 4'hf, 1'b0, 1'b1, 32'h0000_0000},
   '{1'b0, 32'h0000_0100, 8'd7, 4'd6,  32'h0000_0000, 4'h0, 1'b1, 1'b0, 32'h2000_0000},
   '{1'b0, 32'h0000_0000, 8'd3, 4'd7,  32'h0000_0000, 4'h0, 1'b1, 1'b0, 32'h1000_0000},
   '{1'b0, 32'h0000_000c, 8'd0, 4'd8,  32'h0000_0000, 4'h0, 1'b1, 1'b1, 32'h10bb_00de},
   // Wraps from word 255 to word 0.
   '{1'b1, 32'h0000_03f8, 8'd3, 4'd9,  32'h3000_0000, 4'hf, 1'b0, 1'b1, 32'h0000_0000},
   '{1'b0, 32'h0000_03f8, 8'd3, 4'd10, 32'h0000_0000, 4'h0, 1'b1, 1'b0, 32'h3000_0000},
   '{1'b0, 32'h0000_0000, 8'd1, 4'd11, 32'h0000_0000, 4'h0, 1'b0, 1'b1, 32'h3000_0002}
};

/* verification/burst_subsystem_tb.sv */
`timescale 1ns/100ps

module burst_subsystem_tb;

   import burst_pkg::*;

   `include "burst_tb_table.svh"

   localparam int mem_words = 256;

   logic              clk;
   logic              rst_n;
   logic              cmd_valid;
   host_cmd_t         cmd;
   logic              cmd_ready;
   logic              rd_out_valid;
   rd_beat_t          rd_out;
   logic              rd_out_ready;
   logic              wr_done;
   logic [id_w-1:0]   wr_done_id;

   logic [data_w-1:0] ref_mem [mem_words];      // Reference copy of the slave memory.
   rd_beat_t          exp_beats [$];
   logic [id_w-1:0]   exp_done_ids [$];
   logic              rand_ready;
   integer            seed;
   int                cycle_count;

   burst_subsystem_top #(
      .mem_words (mem_words)
   ) dut0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd_valid    (cmd_valid),
      .cmd          (cmd),
      .cmd_ready    (cmd_ready),
      .rd_out_valid (rd_out_valid),
      .rd_out       (rd_out),
      .rd_out_ready (rd_out_ready),
      .wr_done      (wr_done),
      .wr_done_id   (wr_done_id)
   );

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      stop_on_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   function automatic int total_beats();
      int sum;
      sum = 0;
      for (int r = 0; r < n_rows; r++) begin
         sum += int'(table_rows[r].len) + 1;
      end
      return sum;
   endfunction

   task automatic write_reference(input table_entry_t row);
      logic [data_w-1:0] value;
      int                idx;
      for (int i = 0; i <= int'(row.len); i++) begin
         idx   = (int'(row.addr >> 2) + i) % mem_words;
         value = row.data + data_w'(i);
         for (int b = 0; b < strb_w; b++) begin
            if (row.strb[b]) begin
               ref_mem[idx][8*b +: 8] = value[8*b +: 8];
            end
         end
      end
   endtask

   task automatic queue_read(input table_entry_t row);
      rd_beat_t beat;
      int       idx;
      for (int i = 0; i <= int'(row.len); i++) begin
         idx       = (int'(row.addr >> 2) + i) % mem_words;
         beat.data = ref_mem[idx];
         beat.id   = row.id;
         beat.last = (i == int'(row.len));
         if (i == 0) begin
            assert (beat.data == row.exp_first)
               else report_mismatch("reference first word", beat.data, row.exp_first);
         end
         exp_beats.push_back(beat);
      end
   endtask

   task automatic send_cmd(input host_cmd_t c);
      @(posedge clk);
      #1;
      cmd_valid = 1'b1;
      cmd       = c;
      while (!cmd_ready) begin
         @(posedge clk);
         #1;
      end
      @(posedge clk);                            // Command taken at this edge.
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic wait_reads_drained();
      while (exp_beats.size() != 0) begin
         @(posedge clk);
      end
   endtask

   task automatic wait_writes_done();
      while (exp_done_ids.size() != 0) begin
         @(posedge clk);
      end
   endtask

   task automatic run_entry(input table_entry_t row);
      host_cmd_t c;
      c.is_write = row.is_write;
      c.addr     = row.addr;
      c.len      = row.len;
      c.id       = row.id;
      c.data     = row.data;
      c.strb     = row.strb;
      if (row.is_write) begin
         wait_reads_drained();                   // A queued read must not see this burst.
         write_reference(row);
         exp_done_ids.push_back(row.id);
         send_cmd(c);
         wait_writes_done();
      end else begin
         rand_ready = row.rand_ready;
         queue_read(row);
         send_cmd(c);
         if (row.wait_done) begin
            wait_reads_drained();
         end
      end
   endtask

   task automatic check_read_beat();
      rd_beat_t exp;
      if (exp_beats.size() == 0) begin
         stop_on_error("read beat returned with no read outstanding");
      end else begin
         exp = exp_beats.pop_front();
         assert (rd_out.data == exp.data) else report_mismatch("rd_out.data", rd_out.data, exp.data);
         assert (rd_out.id == exp.id) else report_mismatch("rd_out.id", rd_out.id, exp.id);
         assert (rd_out.last == exp.last) else report_mismatch("rd_out.last", rd_out.last, exp.last);
      end
   endtask

   task automatic check_write_done();
      logic [id_w-1:0] exp_id;
      if (exp_done_ids.size() == 0) begin
         stop_on_error("wr_done pulsed with no write outstanding");
      end else begin
         exp_id = exp_done_ids.pop_front();
         assert (wr_done_id == exp_id) else report_mismatch("wr_done_id", wr_done_id, exp_id);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Outputs are stable at the falling edge, ahead of the handshake edge.
   always @(negedge clk) begin
      if (rst_n && rd_out_valid && rd_out_ready) check_read_beat();
      if (rst_n && wr_done) check_write_done();
   end

   always @(posedge clk) begin
      #1;
      if (rand_ready) rd_out_ready = 1'($random(seed));
      else rd_out_ready = 1'b1;
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > 20 * total_beats() + 200) begin
         stop_on_error($sformatf("Timeout, run did not finish within %0d cycles", cycle_count));
      end
   end

   initial begin
      seed         = 32'hdf54_1514;
      cycle_count  = 0;
      rst_n        = 1'b0;
      cmd_valid    = 1'b0;
      cmd          = '0;
      rd_out_ready = 1'b1;
      rand_ready   = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      assert (!rd_out_valid && !wr_done)
         else stop_on_error("rd_out_valid or wr_done is high after reset");
      assert (!cmd_ready) else stop_on_error("cmd_ready is high in the first cycle after reset");
      @(posedge clk);
      #1;
      assert (cmd_ready) else stop_on_error("cmd_ready did not rise one cycle after reset");
      for (int r = 0; r < n_rows; r++) begin
         run_entry(table_rows[r]);
      end
      wait_reads_drained();
      wait_writes_done();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule
